// File: sim.f
design/regfile_pkg.sv
design/read_req_if.sv
design/bypass_match.sv
design/reg_storage.sv
design/operand_select.sv
design/regfile_bypass_top.sv
tests/regfile_bypass_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f sim.f \
  --top-module regfile_bypass_tb \
  -Mdir obj_dir \
  -o regfile_bypass_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit "$status"
fi

./obj_dir/regfile_bypass_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished without errors"
exit 0

// File: tests/regfile_bypass_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file with bypass testbench
// Hand-written table of directed rows, then random back-to-back rows
// checked against a behavioral register array.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regfile_bypass_tb
  import regfile_pkg::*;
  ();

  localparam int NUM_READ     = 3;
  localparam int NUM_WRITE    = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 200;
  localparam int DRAIN_ROWS   = 2; // Pipeline depth.

  // One cycle of stimulus, with the result expected two cycles later.
  typedef struct packed {
    logic      [NUM_WRITE-1:0] we;
    reg_addr_t [NUM_WRITE-1:0] wa;
    reg_data_t [NUM_WRITE-1:0] wd;
    logic                      stb;
    reg_addr_t [NUM_READ-1:0]  ra;
    logic      [NUM_READ-1:0]  ce;
    logic      [NUM_READ-1:0]  oe;
    reg_data_t                 imm; // Port r gets imm + r.
    reg_data_t [NUM_READ-1:0]  exp_d;
    logic      [NUM_READ-1:0]  exp_b;
  } row_t;

  typedef struct packed {
    logic                     v;
    reg_data_t [NUM_READ-1:0] d;
    logic      [NUM_READ-1:0] b;
  } exp_t;

  logic                 clk;
  logic                 rst;
  logic                 rd_strobe;
  reg_addr_t            rd_addr [NUM_READ];
  logic [NUM_READ-1:0]  rd_const_en;
  logic [NUM_READ-1:0]  rd_oe;
  reg_data_t            rd_const [NUM_READ];
  logic [NUM_WRITE-1:0] wr_en;
  reg_addr_t            wr_addr [NUM_WRITE];
  reg_data_t            wr_data [NUM_WRITE];
  logic [NUM_READ-1:0]  rd_valid;
  reg_data_t            rd_data [NUM_READ];
  logic [NUM_READ-1:0]  rd_bypassed;

  row_t        stim [$];
  exp_t        pipe [2];       // Expected results in flight.
  reg_data_t   ref_regs [NUM_REGS];
  logic [31:0] rng = 32'd91;
  int          cycles = 0;
  int          cycle_limit = 0;

  regfile_bypass_top #(
    .NUM_READ  (NUM_READ),
    .NUM_WRITE (NUM_WRITE)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .rd_strobe   (rd_strobe),
    .rd_addr     (rd_addr),
    .rd_const_en (rd_const_en),
    .rd_oe       (rd_oe),
    .rd_const    (rd_const),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_bypassed (rd_bypassed)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t want);
    if (got !== want)
    begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, want);
      abort_run();
    end
  endtask

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not end within %0d cycles.", cycle_limit);
      abort_run();
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // File holds writes up to the cycle before, this cycle's writes are forwarded.
  function automatic exp_t predict(input row_t row);
    exp_t e;
    e = '0;
    e.v = row.stb;
    for (int r = 0; r < NUM_READ; r++)
    begin
      if (!row.oe[r])
        e.d[r] = '0;
      else if (row.ce[r])
        e.d[r] = row.imm + reg_data_t'(r);
      else
      begin
        e.d[r] = ref_regs[row.ra[r]];
        for (int w = 0; w < NUM_WRITE; w++)
        begin
          if (row.we[w] && row.wa[w] == row.ra[r])
          begin
            e.d[r] = row.wd[w]; // Highest port wins.
            e.b[r] = 1'b1;
          end
        end
      end
    end
    return e;
  endfunction

  task automatic commit_writes(input row_t row);
    for (int w = 0; w < NUM_WRITE; w++)
    begin
      if (row.we[w])
        ref_regs[row.wa[w]] = row.wd[w];
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus.
  task automatic drive_row(input row_t row);
    rd_strobe   = row.stb;
    rd_const_en = row.ce;
    rd_oe       = row.oe;
    wr_en       = row.we;
    for (int r = 0; r < NUM_READ; r++)
    begin
      rd_addr[r]  = row.ra[r];
      rd_const[r] = row.imm + reg_data_t'(r);
    end
    for (int w = 0; w < NUM_WRITE; w++)
    begin
      wr_addr[w] = row.wa[w];
      wr_data[w] = row.wd[w];
    end
  endtask

  task automatic check_outputs(input exp_t e);
    for (int r = 0; r < NUM_READ; r++)
    begin
      check_flag($sformatf("rd_valid[%0d]", r), rd_valid[r], e.v);
      if (e.v)
      begin
        check_data($sformatf("rd_data[%0d]", r), rd_data[r], e.d[r]);
        check_flag($sformatf("rd_bypassed[%0d]", r), rd_bypassed[r], e.b[r]);
      end
    end
  endtask

  // One cycle. Outputs checked at the falling edge belong to two rows back.
  task automatic run_row(input row_t row, input logic from_model);
    exp_t e;
    @(negedge clk);
    check_outputs(pipe[1]);
    drive_row(row);
    if (from_model)
      e = predict(row);
    else
    begin
      e.v = row.stb;
      e.d = row.exp_d;
      e.b = row.exp_b;
    end
    commit_writes(row);
    pipe[1] = pipe[0];
    pipe[0] = e;
  endtask

  task automatic add_row(input logic [1:0] we, input reg_addr_t wa0, input reg_data_t wd0,
                         input reg_addr_t wa1, input reg_data_t wd1, input logic stb,
                         input reg_addr_t ra0, input reg_addr_t ra1, input reg_addr_t ra2,
                         input logic [2:0] ce, input logic [2:0] oe, input reg_data_t imm,
                         input reg_data_t e0, input reg_data_t e1, input reg_data_t e2,
                         input logic [2:0] eb);
    row_t row;
    row = '0;
    row.we = we;
    row.wa[0] = wa0;
    row.wd[0] = wd0;
    row.wa[1] = wa1;
    row.wd[1] = wd1;
    row.stb = stb;
    row.ra[0] = ra0;
    row.ra[1] = ra1;
    row.ra[2] = ra2;
    row.ce = ce;
    row.oe = oe;
    row.imm = imm;
    row.exp_d[0] = e0;
    row.exp_d[1] = e1;
    row.exp_d[2] = e2;
    row.exp_b = eb;
    stim.push_back(row);
  endtask

  task automatic make_random_row(output row_t row);
    row = '0;
    rng = xorshift32(rng);
    row.we    = rng[1:0];
    row.wa[0] = reg_addr_t'(rng[4:2]); // Few registers, many collisions.
    row.wa[1] = reg_addr_t'(rng[7:5]);
    row.ra[0] = reg_addr_t'(rng[10:8]);
    row.ra[1] = reg_addr_t'(rng[13:11]);
    row.ra[2] = reg_addr_t'(rng[16:14]);
    row.ce    = rng[19:17] & rng[22:20];
    row.oe    = rng[25:23] | rng[28:26];
    row.stb   = 1'b1;
    rng = xorshift32(rng);
    row.wd[0] = rng;
    rng = xorshift32(rng);
    row.wd[1] = rng;
    rng = xorshift32(rng);
    row.imm = rng;
  endtask

  task automatic build_table();
    // Idle, then reads of a clean file.
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd1, 5'd2, 5'd3,
            3'b000, 3'b111, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    // Older writes come from the file.
    add_row(2'b01, 5'd5, 32'hA5A5_0001, 5'd0, 32'h0, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd5, 5'd5, 5'd5,
            3'b000, 3'b111, 32'h0, 32'hA5A5_0001, 32'hA5A5_0001, 32'hA5A5_0001, 3'b000);
    add_row(2'b10, 5'd0, 32'h0, 5'd6, 32'h0000_0606, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd6, 5'd6, 5'd5,
            3'b000, 3'b111, 32'h0, 32'h0000_0606, 32'h0000_0606, 32'hA5A5_0001, 3'b000);
    // Same-cycle write is forwarded, the next one is not seen.
    add_row(2'b01, 5'd7, 32'h0707_0707, 5'd0, 32'h0, 1'b1, 5'd7, 5'd7, 5'd5,
            3'b000, 3'b111, 32'h0, 32'h0707_0707, 32'h0707_0707, 32'hA5A5_0001, 3'b011);
    add_row(2'b01, 5'd7, 32'hDEAD_0007, 5'd0, 32'h0, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd7, 5'd7, 5'd7,
            3'b000, 3'b111, 32'h0, 32'hDEAD_0007, 32'hDEAD_0007, 32'hDEAD_0007, 3'b000);
    // Both ports on one register.
    add_row(2'b11, 5'd9, 32'h1111_0009, 5'd9, 32'h2222_0009, 1'b1, 5'd9, 5'd9, 5'd9,
            3'b000, 3'b111, 32'h0, 32'h2222_0009, 32'h2222_0009, 32'h2222_0009, 3'b111);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b0, 5'd0, 5'd0, 5'd0,
            3'b000, 3'b000, 32'h0, 32'h0, 32'h0, 32'h0, 3'b000);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd9, 5'd9, 5'd10,
            3'b000, 3'b111, 32'h0, 32'h2222_0009, 32'h2222_0009, 32'h0, 3'b000);
    // Immediate and disabled ports ignore a pending write.
    add_row(2'b01, 5'd12, 32'hC0DE_000C, 5'd0, 32'h0, 1'b1, 5'd12, 5'd12, 5'd12,
            3'b001, 3'b101, 32'hF000_0000, 32'hF000_0000, 32'h0, 32'hC0DE_000C, 3'b100);
    add_row(2'b10, 5'd0, 32'h0, 5'd12, 32'h0BAD_000C, 1'b1, 5'd12, 5'd12, 5'd12,
            3'b010, 3'b011, 32'h1234_5670, 32'h0BAD_000C, 32'h1234_5671, 32'h0, 3'b001);
    add_row(2'b00, 5'd0, 32'h0, 5'd0, 32'h0, 1'b1, 5'd12, 5'd12, 5'd12,
            3'b000, 3'b111, 32'h0, 32'h0BAD_000C, 32'h0BAD_000C, 32'h0BAD_000C, 3'b000);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  initial
  begin
    row_t row;
    build_table();
    cycle_limit = 3 * (stim.size() + NUM_RANDOM + DRAIN_ROWS) + RESET_CYCLES;
    for (int i = 0; i < NUM_REGS; i++)
      ref_regs[i] = '0;
    pipe[0] = '0;
    pipe[1] = '0;
    rst = 1'b1;
    drive_row('0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (stim[i])
      run_row(stim[i], 1'b0);
    repeat (NUM_RANDOM)
    begin
      make_random_row(row);
      run_row(row, 1'b1);
    end
    repeat (DRAIN_ROWS)
      run_row('0, 1'b1); // Flush the last two reads.
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/regfile_bypass_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file with bypass
// Operand read stage. Multi-ported register file with forwarding
// of in-flight writes, two cycles from strobe to data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regfile_bypass_top
  import regfile_pkg::*;
#(
  parameter int NUM_READ  = 3,
  parameter int NUM_WRITE = 2
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 rd_strobe,
  input  wire reg_addr_t            rd_addr [NUM_READ],
  input  wire logic [NUM_READ-1:0]  rd_const_en,
  input  wire logic [NUM_READ-1:0]  rd_oe,
  input  wire reg_data_t            rd_const [NUM_READ],
  input  wire logic [NUM_WRITE-1:0] wr_en,
  input  wire reg_addr_t            wr_addr [NUM_WRITE],
  input  wire reg_data_t            wr_data [NUM_WRITE],
  output logic      [NUM_READ-1:0]  rd_valid,
  output reg_data_t                 rd_data [NUM_READ],
  output logic      [NUM_READ-1:0]  rd_bypassed
);

  logic [NUM_WRITE-1:0] wr_en_q;
  reg_addr_t            wr_addr_q [NUM_WRITE];
  reg_data_t            wr_data_q [NUM_WRITE];
  reg_addr_t            rd_addr_q [NUM_READ];
  reg_data_t            file_data [NUM_READ];

  reg_storage #(
    .NUM_READ  (NUM_READ),
    .NUM_WRITE (NUM_WRITE)
  ) u_storage (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr_q (rd_addr_q),
    .wr_en_q   (wr_en_q),
    .wr_addr_q (wr_addr_q),
    .wr_data_q (wr_data_q),
    .file_data (file_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per read port match and select.
  for (genvar r = 0; r < NUM_READ; r++)
  begin : g_rd
    logic [NUM_WRITE-1:0] match;
    operand_src_e         src;
    reg_data_t            const_q;
    logic                 valid_q;

    read_req_if req ();

    assign req.strobe    = rd_strobe; // Shared by all ports.
    assign req.addr      = rd_addr[r];
    assign req.const_en  = rd_const_en[r];
    assign req.oe        = rd_oe[r];
    assign req.const_val = rd_const[r];

    bypass_match #(
      .NUM_WRITE (NUM_WRITE)
    ) u_match (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .wr_en_q   (wr_en_q),
      .wr_addr_q (wr_addr_q),
      .addr_q    (rd_addr_q[r]),
      .match     (match),
      .src       (src),
      .const_q   (const_q),
      .valid_q   (valid_q)
    );

    operand_select #(
      .NUM_WRITE (NUM_WRITE)
    ) u_select (
      .clk         (clk),
      .rst         (rst),
      .valid_q     (valid_q),
      .src         (src),
      .match       (match),
      .const_q     (const_q),
      .file_data   (file_data[r]),
      .wr_data_q   (wr_data_q),
      .rd_valid    (rd_valid[r]),
      .rd_data     (rd_data[r]),
      .rd_bypassed (rd_bypassed[r])
    );
  end

endmodule

`default_nettype wire

// File: design/operand_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand select
// Picks forwarded, stored, immediate or zero data for one read
// port and registers it with valid and bypass flags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module operand_select
  import regfile_pkg::*;
#(
  parameter int NUM_WRITE = 2
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 valid_q,
  input  wire operand_src_e         src,
  input  wire logic [NUM_WRITE-1:0] match,
  input  wire reg_data_t            const_q,
  input  wire reg_data_t            file_data,
  input  wire reg_data_t            wr_data_q [NUM_WRITE],
  output logic                      rd_valid,
  output reg_data_t                 rd_data,
  output logic                      rd_bypassed
);

  reg_data_t fwd_data;
  reg_data_t sel_data;

  // One-hot match, so an OR of masked data.
  always_comb
  begin
    fwd_data = '0;
    for (int w = 0; w < NUM_WRITE; w++)
    begin
      if (match[w])
        fwd_data = fwd_data | wr_data_q[w];
    end
  end

  always_comb
  begin
    case (src)
      SRC_CONST: sel_data = const_q;
      SRC_FILE:  sel_data = file_data;
      SRC_FWD:   sel_data = fwd_data;
      default:   sel_data = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_valid    <= 1'b0;
      rd_bypassed <= 1'b0;
    end
    else
    begin
      rd_valid    <= valid_q;
      rd_bypassed <= (src == SRC_FWD);
    end
  end

  always_ff @(posedge clk)
    rd_data <= sel_data;

endmodule

`default_nettype wire

// File: design/reg_storage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register storage
// Registers the write ports, commits them into the register array
// and reads the stored value at each held read address.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module reg_storage
  import regfile_pkg::*;
#(
  parameter int NUM_READ  = 3,
  parameter int NUM_WRITE = 2
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [NUM_WRITE-1:0] wr_en,
  input  wire reg_addr_t            wr_addr [NUM_WRITE],
  input  wire reg_data_t            wr_data [NUM_WRITE],
  input  wire reg_addr_t            rd_addr_q [NUM_READ],
  output logic      [NUM_WRITE-1:0] wr_en_q,
  output reg_addr_t                 wr_addr_q [NUM_WRITE],
  output reg_data_t                 wr_data_q [NUM_WRITE],
  output reg_data_t                 file_data [NUM_READ]
);

  reg_data_t regs [NUM_REGS];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write bus register.
  always_ff @(posedge clk)
  begin
    if (rst)
      wr_en_q <= '0;
    else
      wr_en_q <= wr_en;
  end

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < NUM_WRITE; w++)
    begin
      wr_addr_q[w] <= wr_addr[w];
      wr_data_q[w] <= wr_data[w];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Array commit. Later port overrides earlier on the same register.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int w = 0; w < NUM_WRITE; w++)
      begin
        if (wr_en_q[w])
          regs[wr_addr_q[w]] <= wr_data_q[w];
      end
    end
  end

  always_comb
  begin
    for (int r = 0; r < NUM_READ; r++)
      file_data[r] = regs[rd_addr_q[r]]; // Stored value only.
  end

endmodule

`default_nettype wire

// File: design/bypass_match.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass match
// Holds one read request and compares it against the registered
// write bus, giving a one-hot match and the operand source.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module bypass_match
  import regfile_pkg::*;
#(
  parameter int NUM_WRITE = 2
)
(
  input  wire logic                 clk,
  input  wire logic                 rst,
  read_req_if.match                 req,
  input  wire logic [NUM_WRITE-1:0] wr_en_q,
  input  wire reg_addr_t            wr_addr_q [NUM_WRITE],
  output reg_addr_t                 addr_q,
  output logic      [NUM_WRITE-1:0] match,
  output operand_src_e              src,
  output reg_data_t                 const_q,
  output logic                      valid_q
);

  logic const_en_q;
  logic oe_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q     <= '0;
      const_en_q <= 1'b0;
      oe_q       <= 1'b0;
      const_q    <= '0;
      valid_q    <= 1'b0;
    end
    else
    begin
      valid_q <= req.strobe;
      if (req.strobe) // Request held until the next strobe.
      begin
        addr_q     <= req.addr;
        const_en_q <= req.const_en;
        oe_q       <= req.oe;
        const_q    <= req.const_val;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare against the write bus, highest port kept.
  always_comb
  begin
    match = '0;
    for (int w = 0; w < NUM_WRITE; w++)
    begin
      if (wr_en_q[w] && wr_addr_q[w] == addr_q && !const_en_q && oe_q)
      begin
        match    = '0;
        match[w] = 1'b1;
      end
    end
  end

  always_comb
  begin
    if (!oe_q)
      src = SRC_ZERO;
    else if (const_en_q)
      src = SRC_CONST;
    else if (|match)
      src = SRC_FWD;
    else
      src = SRC_FILE; // No match.
  end

endmodule

`default_nettype wire

// File: design/read_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read request bundle
// One read port's strobe, address, constant and output enables.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface read_req_if
  import regfile_pkg::*;
  ();

  logic      strobe;    // Shared read strobe.
  reg_addr_t addr;
  logic      const_en;  // Take the immediate.
  logic      oe;        // Output enable.
  reg_data_t const_val;

  modport top
  (
    output strobe,
    output addr,
    output const_en,
    output oe,
    output const_val
  );

  modport match
  (
    input strobe,
    input addr,
    input const_en,
    input oe,
    input const_val
  );

endinterface

`default_nettype wire

// File: design/regfile_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file types
// Address, data and operand-source definitions shared by the
// operand read stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package regfile_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W; // Architectural registers.
  localparam int DATA_W     = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0]     reg_data_t;

  // Where an operand is taken from.
  typedef enum logic [1:0]
  {
    SRC_ZERO,  // Output disabled.
    SRC_CONST, // Immediate.
    SRC_FILE,  // Stored register.
    SRC_FWD    // In-flight write.
  } operand_src_e;

endpackage

`default_nettype wire
